// File: flist.f
rv_decode_pkg.sv
rv_i_decoder.sv
rv_m_decoder.sv
rv_decoder.sv
rv_id_stage.sv
rv_id_stage_props.sv
tb_rv_id_stage.sv

// File: run.sh
#!/bin/sh
# Compile and run the RV32 decode-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_rv_id_stage

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module "$TOP" -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: rv_decode_pkg.sv
// RV32 decode package with control enums, pipeline structs and the illegal-instruction bundle
package rv_decode_pkg;

  //////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////

  typedef enum logic [5:0] {
    ALU_ADD  = 6'b011000,
    ALU_SUB  = 6'b011001,
    ALU_XOR  = 6'b101111,
    ALU_OR   = 6'b101110,
    ALU_AND  = 6'b010101,
    ALU_SLL  = 6'b100111,
    ALU_SRL  = 6'b100101,
    ALU_SRA  = 6'b100100,
    ALU_SLT  = 6'b000010,
    ALU_SLTU = 6'b000011,
    ALU_EQ   = 6'b001100, // Branch comparisons from here on
    ALU_NE   = 6'b001101,
    ALU_LT   = 6'b000000,
    ALU_GE   = 6'b001010,
    ALU_LTU  = 6'b000001,
    ALU_GEU  = 6'b001011
  } alu_opcode_e;

  typedef enum logic [1:0] {
    OP_A_REGA   = 2'b00, // rs1
    OP_A_CURRPC = 2'b01, // PC of this instruction
    OP_A_IMM    = 2'b10, // Zero-extended rs1 field (CSR immediate forms)
    OP_A_NONE   = 2'b11  // Constant zero
  } alu_op_a_mux_e;

  typedef enum logic [1:0] {
    OP_B_REGB = 2'b00,
    OP_B_IMM  = 2'b01,
    OP_B_NONE = 2'b10
  } alu_op_b_mux_e;

  typedef enum logic [1:0] {
    IMMB_I      = 2'b00,
    IMMB_S      = 2'b01,
    IMMB_U      = 2'b10,
    IMMB_PCINCR = 2'b11 // Link address increment
  } imm_b_mux_e;

  typedef enum logic [1:0] {
    JT_JAL  = 2'b00,
    JT_JALR = 2'b01,
    JT_COND = 2'b10
  } jt_mux_e;

  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } ctrl_transfer_e;

  typedef enum logic [1:0] {
    MUL_M32 = 2'b00, // Lower 32 bits of the product
    MUL_H   = 2'b01  // Upper 32 bits, signedness from mul_signed_mode
  } mul_opcode_e;

  typedef enum logic [1:0] {
    DIV_DIV  = 2'b00,
    DIV_DIVU = 2'b01,
    DIV_REM  = 2'b10,
    DIV_REMU = 2'b11
  } div_opcode_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_opcode_e;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_type_e;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] instr;
    logic        illegal_c_insn; // Compressed expansion failed in fetch
    logic        deassert;       // Suppress side effects of this word
  } if_id_pipe_t;

  typedef struct packed {
    logic           illegal_insn;
    logic           alu_en;
    alu_opcode_e    alu_operator;
    alu_op_a_mux_e  alu_op_a_mux_sel;
    alu_op_b_mux_e  alu_op_b_mux_sel;
    imm_b_mux_e     imm_b_mux_sel;
    logic           mul_en;
    mul_opcode_e    mul_operator;
    logic [1:0]     mul_signed_mode; // {rs2 signed, rs1 signed}
    logic           div_en;
    div_opcode_e    div_operator;
    logic [1:0]     rf_re;           // {rs2, rs1} read enables
    logic           rf_we;
    logic           csr_en;
    csr_opcode_e    csr_op;
    logic           lsu_en;
    logic           lsu_we;
    lsu_type_e      lsu_type;
    logic           lsu_sign_ext;
    logic           sys_en;
    logic           sys_ecall_insn;
    logic           sys_ebrk_insn;
    logic           sys_mret_insn;
    logic           sys_dret_insn;
    logic           sys_wfi_insn;
    logic           sys_fencei_insn;
    ctrl_transfer_e ctrl_transfer_insn;
    jt_mux_e        ctrl_transfer_target_mux_sel;
  } decoder_ctrl_t;

  typedef struct packed {
    logic           rf_we;
    logic           lsu_en;
    ctrl_transfer_e ctrl_transfer_insn;
  } decoder_raw_t;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_AUIPC  = 7'h17;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;
  localparam logic [6:0] OPCODE_FENCE  = 7'h0f;

  // Returned by a sub-decoder that does not recognize the word
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn                 : 1'b1,
    alu_en                       : 1'b0,
    alu_operator                 : ALU_ADD,
    alu_op_a_mux_sel             : OP_A_REGA,
    alu_op_b_mux_sel             : OP_B_REGB,
    imm_b_mux_sel                : IMMB_I,
    mul_en                       : 1'b0,
    mul_operator                 : MUL_M32,
    mul_signed_mode              : 2'b00,
    div_en                       : 1'b0,
    div_operator                 : DIV_DIV,
    rf_re                        : 2'b00,
    rf_we                        : 1'b0,
    csr_en                       : 1'b0,
    csr_op                       : CSR_OP_READ,
    lsu_en                       : 1'b0,
    lsu_we                       : 1'b0,
    lsu_type                     : LSU_WORD,
    lsu_sign_ext                 : 1'b0,
    sys_en                       : 1'b0,
    sys_ecall_insn               : 1'b0,
    sys_ebrk_insn                : 1'b0,
    sys_mret_insn                : 1'b0,
    sys_dret_insn                : 1'b0,
    sys_wfi_insn                 : 1'b0,
    sys_fencei_insn              : 1'b0,
    ctrl_transfer_insn           : BRANCH_NONE,
    ctrl_transfer_target_mux_sel : JT_JAL
  };

endpackage

// File: rv_decode_testdata.txt
// Columns: instr, illegal_c, deassert, expected id_ctrl_o (44 bits), expected id_raw_o
// Raw column is {rf_we, lsu_en, ctrl_transfer_insn}
00500093 0 0 58100182000 8 // ADDI x1, x0, 5
002081B3 0 0 58000382000 8 // ADD x3, x1, x2
402081B3 0 0 59000382000 8 // SUB x3, x1, x2
0080A283 0 0 1810018A800 C // LW x5, 8(x1)
00208223 0 0 1814030C000 4 // SB x2, 4(x1)
00208463 0 0 4C00030200E 3 // BEQ x1, x2, +8
010000EF 0 0 585C0082004 9 // JAL x1, +16
000280E7 0 0 585C0182009 A // JALR x1, 0(x5)
123453B7 0 0 58D80082000 8 // LUI x7, 0x12345
3000A373 0 0 181001E2000 8 // CSRRS x6, mstatus, x1
0000100F 0 0 18000002410 0 // FENCE.I
022081B3 0 0 18020382000 8 // MUL
0220B1B3 0 0 18028382000 8 // MULHU
0220C1B3 0 0 18001382000 8 // DIV
0220F1B3 0 0 18001F82000 8 // REMU
00000000 0 0 98000002000 0 // All-zero word
7B200073 0 0 98000002000 0 // DRET, never legal here
0000007F 0 0 98000002000 0 // Unknown opcode
002081B3 1 0 98000002000 0 // ADD flagged as bad compressed
00500093 0 1 18100102000 8 // ADDI suppressed
0080A283 0 1 18100102800 C // LW suppressed
00208463 0 1 0C000302002 3 // BEQ suppressed
010000EF 0 1 185C0002000 9 // JAL suppressed
3000A373 0 1 18100142000 8 // CSRRS suppressed, csr_op back to read
022081B3 0 1 18000302000 8 // MUL suppressed
0220C1B3 0 1 18000302000 8 // DIV suppressed
00000000 0 1 18000002000 0 // Illegal word suppressed
0000100F 0 1 18000002010 0 // FENCE.I suppressed

// File: rv_decoder.sv
// Decoder that merges the RV32I and RV32M sub-decoders and gates the enables
module rv_decoder import rv_decode_pkg::*; (
  input  if_id_pipe_t   if_id_pipe_i,
  input  logic          deassert_we_i, // Suppress side effects of the held word
  output decoder_ctrl_t ctrl_o,
  output decoder_raw_t  raw_o
);

  decoder_ctrl_t decoder_i_ctrl;
  decoder_ctrl_t decoder_m_ctrl;
  decoder_ctrl_t decoder_ctrl_mux_subdec; // Winner of the priority mux
  decoder_ctrl_t decoder_ctrl_mux;        // After the compressed-illegal override

  //////////////////////////////////////////////////
  // Sub-decoders
  //////////////////////////////////////////////////

  rv_i_decoder i_decoder_i (
    .instr_rdata_i  ( if_id_pipe_i.instr ),
    .decoder_ctrl_o ( decoder_i_ctrl     )
  );

  rv_m_decoder m_decoder_i (
    .instr_rdata_i  ( if_id_pipe_i.instr ),
    .decoder_ctrl_o ( decoder_m_ctrl     )
  );

  // M checked first, then I
  always_comb begin
    if (!decoder_m_ctrl.illegal_insn) begin
      decoder_ctrl_mux_subdec = decoder_m_ctrl;
    end else if (!decoder_i_ctrl.illegal_insn) begin
      decoder_ctrl_mux_subdec = decoder_i_ctrl;
    end else begin
      decoder_ctrl_mux_subdec = DECODER_CTRL_ILLEGAL_INSN; // Nobody claimed the word
    end
  end

  assign decoder_ctrl_mux = if_id_pipe_i.illegal_c_insn ? DECODER_CTRL_ILLEGAL_INSN
                                                        : decoder_ctrl_mux_subdec;

  //////////////////////////////////////////////////
  // Suppression
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_o = decoder_ctrl_mux;
    if (deassert_we_i) begin
      ctrl_o.alu_en             = 1'b0;
      ctrl_o.mul_en             = 1'b0;
      ctrl_o.div_en             = 1'b0;
      ctrl_o.lsu_en             = 1'b0;
      ctrl_o.sys_en             = 1'b0;
      ctrl_o.rf_we              = 1'b0;
      ctrl_o.illegal_insn       = 1'b0;
      ctrl_o.ctrl_transfer_insn = BRANCH_NONE;
      ctrl_o.csr_op             = CSR_OP_READ; // csr_en stays, a read has no side effect
    end
  end

  // Ungated copies for hazard detection
  assign raw_o.rf_we              = decoder_ctrl_mux.rf_we;
  assign raw_o.lsu_en             = decoder_ctrl_mux.lsu_en;
  assign raw_o.ctrl_transfer_insn = decoder_ctrl_mux.ctrl_transfer_insn;

endmodule

// File: rv_i_decoder.sv
// RV32I base-integer decoder, maps one instruction word onto a control bundle
module rv_i_decoder import rv_decode_pkg::*; (
  input  logic [31:0]   instr_rdata_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  always_comb begin
    decoder_ctrl_o              = DECODER_CTRL_ILLEGAL_INSN; // Start from all enables clear
    decoder_ctrl_o.illegal_insn = 1'b0;

    case (opcode)
      //////////////////////////////////////////////////
      // Jumps and upper immediates
      //////////////////////////////////////////////////
      OPCODE_JAL, OPCODE_JALR: begin
        decoder_ctrl_o.alu_en           = 1'b1;       // ALU forms the link address
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_CURRPC;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_b_mux_sel    = IMMB_PCINCR;
        decoder_ctrl_o.rf_we            = 1'b1;
        if (opcode == OPCODE_JAL) begin
          decoder_ctrl_o.ctrl_transfer_insn           = BRANCH_JAL;
          decoder_ctrl_o.ctrl_transfer_target_mux_sel = JT_JAL;
        end else begin
          decoder_ctrl_o.ctrl_transfer_insn           = BRANCH_JALR;
          decoder_ctrl_o.ctrl_transfer_target_mux_sel = JT_JALR;
          decoder_ctrl_o.rf_re[0]                     = 1'b1; // Target base from rs1
          if (funct3 != 3'b000) decoder_ctrl_o.illegal_insn = 1'b1;
        end
      end

      OPCODE_LUI, OPCODE_AUIPC: begin
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.alu_op_a_mux_sel = (opcode == OPCODE_LUI) ? OP_A_NONE : OP_A_CURRPC;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_b_mux_sel    = IMMB_U;
        decoder_ctrl_o.rf_we            = 1'b1;
      end

      OPCODE_BRANCH: begin
        decoder_ctrl_o.ctrl_transfer_insn           = BRANCH_COND;
        decoder_ctrl_o.ctrl_transfer_target_mux_sel = JT_COND;
        decoder_ctrl_o.alu_en                       = 1'b1; // Comparison only
        decoder_ctrl_o.rf_re                        = 2'b11;
        case (funct3)
          3'b000:  decoder_ctrl_o.alu_operator = ALU_EQ;
          3'b001:  decoder_ctrl_o.alu_operator = ALU_NE;
          3'b100:  decoder_ctrl_o.alu_operator = ALU_LT;
          3'b101:  decoder_ctrl_o.alu_operator = ALU_GE;
          3'b110:  decoder_ctrl_o.alu_operator = ALU_LTU;
          3'b111:  decoder_ctrl_o.alu_operator = ALU_GEU;
          default: decoder_ctrl_o.illegal_insn = 1'b1;
        endcase
      end

      //////////////////////////////////////////////////
      // Loads and stores
      //////////////////////////////////////////////////
      OPCODE_LOAD, OPCODE_STORE: begin
        decoder_ctrl_o.lsu_en           = 1'b1;
        decoder_ctrl_o.lsu_type         = lsu_type_e'(funct3[1:0]);
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM; // Address offset
        if (opcode == OPCODE_LOAD) begin
          decoder_ctrl_o.rf_re[0]     = 1'b1;
          decoder_ctrl_o.rf_we        = 1'b1;
          decoder_ctrl_o.lsu_sign_ext = ~funct3[2];
          // No LD, and LWU is RV64 only
          if (funct3[1:0] == 2'b11 || funct3 == 3'b110) decoder_ctrl_o.illegal_insn = 1'b1;
        end else begin
          decoder_ctrl_o.rf_re         = 2'b11; // Base and store data
          decoder_ctrl_o.lsu_we        = 1'b1;
          decoder_ctrl_o.imm_b_mux_sel = IMMB_S;
          if (funct3[2] || funct3[1:0] == 2'b11) decoder_ctrl_o.illegal_insn = 1'b1;
        end
      end

      //////////////////////////////////////////////////
      // Register-immediate and register-register ALU
      //////////////////////////////////////////////////
      OPCODE_OPIMM: begin
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.rf_re[0]         = 1'b1;
        decoder_ctrl_o.rf_we            = 1'b1;
        case (funct3)
          3'b000: decoder_ctrl_o.alu_operator = ALU_ADD;
          3'b010: decoder_ctrl_o.alu_operator = ALU_SLT;
          3'b011: decoder_ctrl_o.alu_operator = ALU_SLTU;
          3'b100: decoder_ctrl_o.alu_operator = ALU_XOR;
          3'b110: decoder_ctrl_o.alu_operator = ALU_OR;
          3'b111: decoder_ctrl_o.alu_operator = ALU_AND;
          3'b001: begin
            decoder_ctrl_o.alu_operator = ALU_SLL;
            if (funct7 != 7'b0000000) decoder_ctrl_o.illegal_insn = 1'b1; // shamt[5] set
          end
          default: begin // 3'b101, shift right
            case (funct7)
              7'b0000000: decoder_ctrl_o.alu_operator = ALU_SRL;
              7'b0100000: decoder_ctrl_o.alu_operator = ALU_SRA;
              default:    decoder_ctrl_o.illegal_insn = 1'b1;
            endcase
          end
        endcase
      end

      OPCODE_OP: begin
        decoder_ctrl_o.alu_en = 1'b1;
        decoder_ctrl_o.rf_re  = 2'b11;
        decoder_ctrl_o.rf_we  = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: decoder_ctrl_o.alu_operator = ALU_ADD;
          {7'b0100000, 3'b000}: decoder_ctrl_o.alu_operator = ALU_SUB;
          {7'b0000000, 3'b001}: decoder_ctrl_o.alu_operator = ALU_SLL;
          {7'b0000000, 3'b010}: decoder_ctrl_o.alu_operator = ALU_SLT;
          {7'b0000000, 3'b011}: decoder_ctrl_o.alu_operator = ALU_SLTU;
          {7'b0000000, 3'b100}: decoder_ctrl_o.alu_operator = ALU_XOR;
          {7'b0000000, 3'b101}: decoder_ctrl_o.alu_operator = ALU_SRL;
          {7'b0100000, 3'b101}: decoder_ctrl_o.alu_operator = ALU_SRA;
          {7'b0000000, 3'b110}: decoder_ctrl_o.alu_operator = ALU_OR;
          {7'b0000000, 3'b111}: decoder_ctrl_o.alu_operator = ALU_AND;
          default:              decoder_ctrl_o.illegal_insn = 1'b1; // Includes M encodings
        endcase
      end

      //////////////////////////////////////////////////
      // Fences, system and CSR
      //////////////////////////////////////////////////
      OPCODE_FENCE: begin
        case (funct3)
          3'b000: decoder_ctrl_o.alu_en = 1'b1; // FENCE runs as a NOP with no writeback
          3'b001: begin
            decoder_ctrl_o.sys_en          = 1'b1;
            decoder_ctrl_o.sys_fencei_insn = 1'b1;
          end
          default: decoder_ctrl_o.illegal_insn = 1'b1;
        endcase
      end

      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          decoder_ctrl_o.sys_en = 1'b1;
          if (instr_rdata_i[19:7] != '0) begin
            decoder_ctrl_o.illegal_insn = 1'b1;     // rs1 and rd must be x0
          end else begin
            case (instr_rdata_i[31:20])
              12'h000: decoder_ctrl_o.sys_ecall_insn = 1'b1;
              12'h001: decoder_ctrl_o.sys_ebrk_insn  = 1'b1;
              12'h302: decoder_ctrl_o.sys_mret_insn  = 1'b1;
              12'h105: decoder_ctrl_o.sys_wfi_insn   = 1'b1;
              default: decoder_ctrl_o.illegal_insn   = 1'b1; // DRET lands here
            endcase
          end
        end else if (funct3 == 3'b100) begin
          decoder_ctrl_o.illegal_insn = 1'b1;
        end else begin
          decoder_ctrl_o.csr_en           = 1'b1;
          decoder_ctrl_o.rf_we            = 1'b1;
          decoder_ctrl_o.rf_re[0]         = ~funct3[2];    // Immediate forms read no register
          decoder_ctrl_o.alu_op_a_mux_sel = funct3[2] ? OP_A_IMM : OP_A_REGA;
          decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;      // CSR address
          decoder_ctrl_o.csr_op           = csr_opcode_e'(funct3[1:0]);
          // Set or clear with a zero mask writes nothing
          if (funct3[1] && instr_rdata_i[19:15] == 5'd0) decoder_ctrl_o.csr_op = CSR_OP_READ;
        end
      end

      default: decoder_ctrl_o.illegal_insn = 1'b1;
    endcase

    // Partial decode results must not leak on an illegal word
    if (decoder_ctrl_o.illegal_insn) decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
  end

endmodule

// File: rv_id_stage.sv
// Instruction decode stage, holds the fetched word and decodes it into control
module rv_id_stage import rv_decode_pkg::*; (
  input  logic          clk,
  input  logic          reset_i,
  input  logic          fetch_valid_i, // One-cycle load strobe
  input  if_id_pipe_t   if_id_i,
  input  logic          deassert_we_i, // Captured with the word
  output decoder_ctrl_t id_ctrl_o,
  output decoder_raw_t  id_raw_o
);

  if_id_pipe_t if_id_q;
  logic        valid_q;     // Set once any word has been loaded
  logic        deassert_we;

  //////////////////////////////////////////////////
  // Instruction register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      if_id_q <= '0;        // Zero word decodes as illegal
      valid_q <= 1'b0;
    end else if (fetch_valid_i) begin
      if_id_q.instr          <= if_id_i.instr;
      if_id_q.illegal_c_insn <= if_id_i.illegal_c_insn;
      if_id_q.deassert       <= deassert_we_i; // Level at load time wins over fetch's bit
      valid_q                <= 1'b1;
    end
  end

  // Nothing held counts as suppressed
  assign deassert_we = if_id_q.deassert | ~valid_q;

  rv_decoder decoder_i (
    .if_id_pipe_i  ( if_id_q     ),
    .deassert_we_i ( deassert_we ),
    .ctrl_o        ( id_ctrl_o   ),
    .raw_o         ( id_raw_o    )
  );

endmodule

// File: rv_id_stage_props.sv
// Decode-stage output properties, bound onto rv_id_stage
module rv_id_stage_props import rv_decode_pkg::*; (
  input logic          clk,
  input logic          reset_i,
  input decoder_ctrl_t id_ctrl_o,
  input decoder_raw_t  id_raw_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // One execution unit per instruction
  a_one_unit: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({id_ctrl_o.alu_en, id_ctrl_o.mul_en, id_ctrl_o.div_en}))
    else $error("More than one of alu_en, mul_en, div_en is set");

  // Illegal word must not start anything
  a_illegal_quiet: assert property (@(posedge clk) disable iff (reset_i)
    id_ctrl_o.illegal_insn |-> !(id_ctrl_o.alu_en || id_ctrl_o.mul_en || id_ctrl_o.div_en ||
                                 id_ctrl_o.lsu_en || id_ctrl_o.sys_en || id_ctrl_o.rf_we ||
                                 id_ctrl_o.csr_en))
    else $error("illegal_insn set together with an enable");

  //////////////////////////////////////////////////
  // Gated outputs never exceed the raw copies
  //////////////////////////////////////////////////
  a_rf_we_raw: assert property (@(posedge clk) disable iff (reset_i)
    id_ctrl_o.rf_we |-> id_raw_o.rf_we) else $error("rf_we set without raw rf_we");
  a_lsu_en_raw: assert property (@(posedge clk) disable iff (reset_i)
    id_ctrl_o.lsu_en |-> id_raw_o.lsu_en) else $error("lsu_en set without raw lsu_en");
  a_transfer_raw: assert property (@(posedge clk) disable iff (reset_i)
    (id_ctrl_o.ctrl_transfer_insn != BRANCH_NONE) |->
      (id_ctrl_o.ctrl_transfer_insn == id_raw_o.ctrl_transfer_insn))
    else $error("Transfer type differs from raw copy");

endmodule

bind rv_id_stage rv_id_stage_props i_props (
  .clk       ( clk       ),
  .reset_i   ( reset_i   ),
  .id_ctrl_o ( id_ctrl_o ),
  .id_raw_o  ( id_raw_o  )
);

// File: rv_m_decoder.sv
// RV32M multiply/divide decoder, recognizes the MULDIV group of the OP opcode
module rv_m_decoder import rv_decode_pkg::*; (
  input  logic [31:0]   instr_rdata_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN; // No match unless OP with funct7 0000001

    if (instr_rdata_i[6:0] == OPCODE_OP && instr_rdata_i[31:25] == 7'b0000001) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.rf_re        = 2'b11;
      decoder_ctrl_o.rf_we        = 1'b1;

      // funct3[2] splits multiplier from divider
      case (instr_rdata_i[14:12])
        3'b000: begin                              // MUL
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_M32;
          decoder_ctrl_o.mul_signed_mode = 2'b00;
        end
        3'b001: begin                              // MULH
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_H;
          decoder_ctrl_o.mul_signed_mode = 2'b11;
        end
        3'b010: begin                              // MULHSU, rs1 signed only
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_H;
          decoder_ctrl_o.mul_signed_mode = 2'b01;
        end
        3'b011: begin                              // MULHU
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_H;
          decoder_ctrl_o.mul_signed_mode = 2'b00;
        end
        default: begin
          decoder_ctrl_o.div_en       = 1'b1;
          decoder_ctrl_o.div_operator = div_opcode_e'(instr_rdata_i[13:12]);
        end
      endcase
    end
  end

endmodule

// File: tb_rv_id_stage.sv
// Testbench for the RV32 decode stage that replays file vectors and checks both output bundles
module tb_rv_id_stage import rv_decode_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_VECTORS   = 28;
  localparam int RESET_TIMEOUT = 20; // In clock cycles

  logic          clk;
  logic          reset_i;
  logic          fetch_valid_i;
  if_id_pipe_t   if_id_i;
  logic          deassert_we_i;
  decoder_ctrl_t id_ctrl_o;
  decoder_raw_t  id_raw_o;

  logic [43:0] vec_mem [0:255]; // Five words per vector
  int          ctrl_errors;
  int          raw_errors;
  int          other_errors;
  int          seed;              // Idle gap generator

  rv_id_stage i_dut (
    .clk           ( clk           ),
    .reset_i       ( reset_i       ),
    .fetch_valid_i ( fetch_valid_i ),
    .if_id_i       ( if_id_i       ),
    .deassert_we_i ( deassert_we_i ),
    .id_ctrl_o     ( id_ctrl_o     ),
    .id_raw_o      ( id_raw_o      )
  );

  initial clk = 1'b0;
  always #2 clk = ~clk; // 4 ns period

  initial begin
    reset_i = 1'b1;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_ctrl(input string name, input decoder_ctrl_t expected,
                            input decoder_ctrl_t actual);
    if (actual !== expected) begin
      ctrl_errors++;
      $display("** Error %s: id_ctrl_o expected %011h, actual %011h", name, expected, actual);
    end
  endtask

  task automatic check_raw(input string name, input decoder_raw_t expected,
                           input decoder_raw_t actual);
    if (actual !== expected) begin
      raw_errors++;
      $display("** Error %s: id_raw_o expected %01h, actual %01h", name, expected, actual);
    end
  endtask

  task automatic wait_reset_release(output bit released);
    int cycles;
    cycles   = 0;
    released = 1'b0;
    while (!released && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (reset_i == 1'b0) released = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // Vector replay
  //////////////////////////////////////////////////
  task automatic run_vectors();
    logic [7:0]    addr;
    logic [31:0]   word;
    logic          illegal_c;
    logic          deassert;
    decoder_ctrl_t exp_ctrl;
    decoder_raw_t  exp_raw;
    string         name;
    int            gap;
    int            idx;
    addr = 8'd0;
    for (idx = 0; idx < NUM_VECTORS; idx++) begin
      word      = vec_mem[addr][31:0];
      illegal_c = vec_mem[addr + 8'd1][0];
      deassert  = vec_mem[addr + 8'd2][0];
      exp_ctrl  = decoder_ctrl_t'(vec_mem[addr + 8'd3]);
      exp_raw   = decoder_raw_t'(vec_mem[addr + 8'd4][3:0]);
      addr      = addr + 8'd5;
      @(posedge clk);
      fetch_valid_i <= 1'b1; // One-cycle strobe
      // Fetch's own deassert bit is inverted so the stage must take the level
      if_id_i       <= '{instr: word, illegal_c_insn: illegal_c, deassert: ~deassert};
      deassert_we_i <= deassert;
      @(posedge clk);        // Word loads here
      fetch_valid_i <= 1'b0;
      @(negedge clk);
      name = $sformatf("vector %0d (instr %08h)", idx, word);
      check_ctrl(name, exp_ctrl, id_ctrl_o);
      check_raw(name, exp_raw, id_raw_o);
      gap = $random(seed) & 3;
      repeat (gap) @(posedge clk);
    end
  endtask

  initial begin
    decoder_ctrl_t reset_ctrl;
    bit            released;
    fetch_valid_i = 1'b0;
    if_id_i       = '0;
    deassert_we_i = 1'b0;
    ctrl_errors   = 0;
    raw_errors    = 0;
    other_errors  = 0;
    seed          = 89;
    $readmemh("rv_decode_testdata.txt", vec_mem);
    if ($isunknown(vec_mem[0]) || vec_mem[0][31:0] == 32'd0) begin
      other_errors++;
      $display("Vector file rv_decode_testdata.txt is missing or empty");
    end

    wait_reset_release(released);
    if (!released) begin
      other_errors++;
      $display("Reset still asserted after %0d cycles", RESET_TIMEOUT);
    end else begin
      // Nothing held yet, so the cleared word is suppressed
      reset_ctrl = decoder_ctrl_t'(44'h18000002000); // Zero word, illegal then suppressed
      @(negedge clk);
      check_ctrl("reset state", reset_ctrl, id_ctrl_o);
      check_raw("reset state", '0, id_raw_o);
      run_vectors();
    end

    $display("Error counts: ctrl %0d, raw %0d, other %0d", ctrl_errors, raw_errors,
             other_errors);
    if (ctrl_errors + raw_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
